// File: rtl/ldqPkg.sv
package ldqPkg;

  // line address, one bank bit per bank, instruction tag
  localparam int ADDR_W = 36;
  localparam int BANK_W = 32;
  localparam int II_W = 10;

  // position within the group sits in the low tag bits
  localparam int II_POS_W = 4;
  localparam int II_GRP_W = II_W - II_POS_W;

  typedef logic [ADDR_W-1:0] lineAddrT;
  typedef logic [BANK_W-1:0] bankMaskT;
  typedef logic [II_W-1:0] iiTagT;

  // group part of a tag
  function automatic logic [II_GRP_W-1:0] iiGroup(input iiTagT tag);
    iiGroup = tag[II_W-1:II_POS_W];
  endfunction

  // position part of a tag
  function automatic logic [II_POS_W-1:0] iiPos(input iiTagT tag);
    iiPos = tag[II_POS_W-1:0];
  endfunction

endpackage

// File: rtl/ldqEntry.sv
`timescale 1ns/1ps

module ldqEntry import ldqPkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     flush,

  input  logic     alloc,
  input  lineAddrT insAddr,
  input  bankMaskT insBanks,
  input  iiTagT    insII,

  input  logic     chkEn,
  input  lineAddrT chkAddr,
  input  bankMaskT chkBanks,
  input  iiTagT    chkII,

  input  logic     retEn,
  input  iiTagT    retII,

  output logic     free,
  output logic     retMatch,
  output logic     conflNext
);

  // stored load
  lineAddrT addr;
  bankMaskT banks;
  iiTagT    tag;

  logic valid;
  logic confl;

  logic addrEq;
  logic bankOverlap;
  logic sameGroup;
  logic olderInGroup;
  logic chkHit;

  always_ff @(posedge clk) begin
    if (alloc) begin
      addr  <= insAddr;
      banks <= insBanks;
      tag   <= insII;
    end
  end

  // store overlap test
  assign addrEq      = (addr == chkAddr);
  assign bankOverlap = |(banks & chkBanks);

  // a load earlier in the store's own group is not hit
  assign sameGroup    = (iiGroup(tag) == iiGroup(chkII));
  assign olderInGroup = sameGroup && (iiPos(tag) < iiPos(chkII));

  assign chkHit = valid && chkEn && addrEq && bankOverlap && !olderInGroup;

  // retire lookup
  assign retMatch = valid && retEn && (tag == retII);

  // includes a check arriving on the retire edge
  assign conflNext = retMatch && (confl || chkHit);

  assign free = !valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= 1'b0;
      confl <= 1'b0;
    end else if (flush) begin
      valid <= 1'b0;
      confl <= 1'b0;
    end else if (alloc) begin
      // only a free entry is granted, so no retire or check can collide here
      valid <= 1'b1;
      confl <= 1'b0;
    end else begin
      if (chkHit) begin
        confl <= 1'b1;
      end
      if (retMatch) begin
        valid <= 1'b0;
      end
    end
  end

endmodule

// File: rtl/ldqArray.sv
`timescale 1ns/1ps

module ldqArray import ldqPkg::*; #(
  parameter int ENTRY_COUNT = 16
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   flush,

  input  logic [ENTRY_COUNT-1:0] grant,
  input  lineAddrT               insAddr,
  input  bankMaskT               insBanks,
  input  iiTagT                  insII,

  input  logic                   chkEn,
  input  lineAddrT               chkAddr,
  input  bankMaskT               chkBanks,
  input  iiTagT                  chkII,

  input  logic                   retEn,
  input  iiTagT                  retII,

  output logic [ENTRY_COUNT-1:0] freeVec,
  output logic                   retHit,
  output logic                   retValid,
  output logic                   retConfl
);

  logic [ENTRY_COUNT-1:0] matchVec;
  logic [ENTRY_COUNT-1:0] conflVec;
  logic                   conflAny;

  for (genvar i = 0; i < ENTRY_COUNT; i++) begin : genEntry
    ldqEntry entry (
      .clk       (clk),
      .rst       (rst),
      .flush     (flush),
      .alloc     (grant[i]),
      .insAddr   (insAddr),
      .insBanks  (insBanks),
      .insII     (insII),
      .chkEn     (chkEn),
      .chkAddr   (chkAddr),
      .chkBanks  (chkBanks),
      .chkII     (chkII),
      .retEn     (retEn),
      .retII     (retII),
      .free      (freeVec[i]),
      .retMatch  (matchVec[i]),
      .conflNext (conflVec[i])
    );
  end

  // tags are unique, so at most one entry answers
  assign retHit   = |matchVec;
  assign conflAny = |conflVec;

  always_ff @(posedge clk) begin
    if (rst) begin
      retValid <= 1'b0;
      retConfl <= 1'b0;
    end else if (flush) begin
      // flush wins over a retire on the same edge
      retValid <= 1'b0;
      retConfl <= 1'b0;
    end else begin
      retValid <= retHit;
      retConfl <= conflAny;
    end
  end

endmodule

// File: rtl/ldqAlloc.sv
`timescale 1ns/1ps

module ldqAlloc import ldqPkg::*; #(
  parameter int ENTRY_COUNT = 16,
  parameter int STALL_CNT   = ENTRY_COUNT - 2
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   flush,

  input  logic                   insEn,
  input  logic [ENTRY_COUNT-1:0] freeVec,
  input  logic                   retHit,

  output logic [ENTRY_COUNT-1:0] grant,
  output logic                   insReady
);

  localparam int CNT_W = $clog2(ENTRY_COUNT + 1);

  logic [CNT_W-1:0]       count;
  logic [ENTRY_COUNT-1:0] firstFree;
  logic                   anyFree;
  logic                   accept;

  // lowest free entry, one-hot
  always_comb begin
    logic found;
    found = 1'b0;
    firstFree = '0;
    for (int i = 0; i < ENTRY_COUNT; i++) begin
      if (freeVec[i] && !found) begin
        firstFree[i] = 1'b1;
        found = 1'b1;
      end
    end
  end

  assign anyFree = |freeVec;

  // back-pressure near full
  assign insReady = anyFree && (count < CNT_W'(STALL_CNT));

  assign accept = insEn && insReady;
  assign grant  = accept ? firstFree : '0;

  // occupancy
  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (flush) begin
      count <= '0;
    end else begin
      case ({accept, retHit})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: rtl/ldqTop.sv
`timescale 1ns/1ps

module ldqTop import ldqPkg::*; #(
  parameter int ENTRY_COUNT = 16,
  parameter int STALL_CNT   = ENTRY_COUNT - 2
) (
  input  logic     clk,
  input  logic     rst,

  // load insert
  input  logic     insEn,
  input  lineAddrT insAddr,
  input  bankMaskT insBanks,
  input  iiTagT    insII,
  output logic     insReady,

  // store address check
  input  logic     chkEn,
  input  lineAddrT chkAddr,
  input  bankMaskT chkBanks,
  input  iiTagT    chkII,

  // load retire
  input  logic     retEn,
  input  iiTagT    retII,
  output logic     retValid,
  output logic     retConfl,

  input  logic     flush
);

  logic [ENTRY_COUNT-1:0] grant;
  logic [ENTRY_COUNT-1:0] freeVec;
  logic                   retHit;

  ldqAlloc #(
    .ENTRY_COUNT (ENTRY_COUNT),
    .STALL_CNT   (STALL_CNT)
  ) alloc (
    .clk      (clk),
    .rst      (rst),
    .flush    (flush),
    .insEn    (insEn),
    .freeVec  (freeVec),
    .retHit   (retHit),
    .grant    (grant),
    .insReady (insReady)
  );

  ldqArray #(
    .ENTRY_COUNT (ENTRY_COUNT)
  ) array (
    .clk      (clk),
    .rst      (rst),
    .flush    (flush),
    .grant    (grant),
    .insAddr  (insAddr),
    .insBanks (insBanks),
    .insII    (insII),
    .chkEn    (chkEn),
    .chkAddr  (chkAddr),
    .chkBanks (chkBanks),
    .chkII    (chkII),
    .retEn    (retEn),
    .retII    (retII),
    .freeVec  (freeVec),
    .retHit   (retHit),
    .retValid (retValid),
    .retConfl (retConfl)
  );

endmodule

// File: tb/ldqTop_assertions.sv
`timescale 1ns/1ps

module ldqTop_assertions (
  input logic clk,
  input logic rst,
  input logic flush,
  input logic retValid,
  input logic retConfl,
  input logic insReady
);

  conflNeedsValid: assert property (@(posedge clk) disable iff (rst) retConfl |-> retValid)
    else $error("retConfl high while retValid is low");

  // retire result is cleared by a flush
  flushClearsRetire: assert property (@(posedge clk) disable iff (rst) flush |=> !retValid)
    else $error("retValid high in the cycle after a flush");

  readyAfterReset: assert property (@(posedge clk) $fell(rst) |-> insReady)
    else $error("insReady low in the first cycle after reset");

endmodule

bind ldqTop ldqTop_assertions topChecks (
  .clk      (clk),
  .rst      (rst),
  .flush    (flush),
  .retValid (retValid),
  .retConfl (retConfl),
  .insReady (insReady)
);

// File: tb/ldqChecker.sv
`timescale 1ns/1ps

module ldqChecker (
  input  logic clk,
  input  logic rst,

  // expected values from the stimulus
  input  logic opValid,
  input  logic expValid,
  input  logic expConfl,
  input  logic expReady,

  // observed DUT outputs
  input  logic insReady,
  input  logic retValid,
  input  logic retConfl,

  output int   mismatches
);

  logic pending;
  logic pendValid;
  logic pendConfl;

  task automatic reportMismatch(input string name, input logic expected, input logic actual);
    $display("MISMATCH at %0t: %s expected %b, got %b", $time, name, expected, actual);
    mismatches = mismatches + 1;
  endtask

  always @(posedge clk) begin
    if (rst) begin
      mismatches = 0;
      pending   <= 1'b0;
      pendValid <= 1'b0;
      pendConfl <= 1'b0;
    end else begin
      // result registered at the previous edge
      if (pending) begin
        if (retValid !== pendValid) begin
          reportMismatch("retValid", pendValid, retValid);
        end
        if (retConfl !== pendConfl) begin
          reportMismatch("retConfl", pendConfl, retConfl);
        end
      end else begin
        if (retValid !== 1'b0) begin
          reportMismatch("retValid", 1'b0, retValid);
        end
        if (retConfl !== 1'b0) begin
          reportMismatch("retConfl", 1'b0, retConfl);
        end
      end

      // ready level in the cycle the operation was presented
      if (opValid) begin
        if (insReady !== expReady) begin
          reportMismatch("insReady", expReady, insReady);
        end
      end

      pending   <= opValid;
      pendValid <= opValid && expValid;
      pendConfl <= opValid && expConfl;
    end
  end

endmodule

// File: tb/ldqTb.sv
`timescale 1ns/1ps

module ldqTb import ldqPkg::*; ();

  // small queue so the stall threshold is reached quickly
  localparam int ENTRY_COUNT   = 8;
  localparam int STALL_CNT     = 6;
  localparam int READY_TIMEOUT = 50;
  localparam int MAX_CYCLES    = 5000;

  localparam logic [3:0] OP_INSERT = 4'h1;
  localparam logic [3:0] OP_CHECK  = 4'h2;
  localparam logic [3:0] OP_RETIRE = 4'h3;
  localparam logic [3:0] OP_FLUSH  = 4'h4;

  logic     clk;
  logic     rst;
  logic     insEn;
  lineAddrT insAddr;
  bankMaskT insBanks;
  iiTagT    insII;
  logic     insReady;
  logic     chkEn;
  lineAddrT chkAddr;
  bankMaskT chkBanks;
  iiTagT    chkII;
  logic     retEn;
  iiTagT    retII;
  logic     retValid;
  logic     retConfl;
  logic     flush;

  // expected values, aligned with the operation they belong to
  logic opValid;
  logic expValid;
  logic expConfl;
  logic expReady;

  int mismatches;
  int timeouts;
  int fileErrors;

  ldqTop #(
    .ENTRY_COUNT (ENTRY_COUNT),
    .STALL_CNT   (STALL_CNT)
  ) dut (
    .clk      (clk),
    .rst      (rst),
    .insEn    (insEn),
    .insAddr  (insAddr),
    .insBanks (insBanks),
    .insII    (insII),
    .insReady (insReady),
    .chkEn    (chkEn),
    .chkAddr  (chkAddr),
    .chkBanks (chkBanks),
    .chkII    (chkII),
    .retEn    (retEn),
    .retII    (retII),
    .retValid (retValid),
    .retConfl (retConfl),
    .flush    (flush)
  );

  ldqChecker check (
    .clk        (clk),
    .rst        (rst),
    .opValid    (opValid),
    .expValid   (expValid),
    .expConfl   (expConfl),
    .expReady   (expReady),
    .insReady   (insReady),
    .retValid   (retValid),
    .retConfl   (retConfl),
    .mismatches (mismatches)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // guard against a run that never reaches its end
  initial begin
    repeat (MAX_CYCLES) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
    $display("errors: %0d mismatches, %0d timeouts, %0d file errors",
             mismatches, timeouts + 1, fileErrors);
    $display("TESTS FAILED");
    $finish;
  end

  task automatic clearInputs();
    opValid  <= 1'b0;
    expValid <= 1'b0;
    expConfl <= 1'b0;
    expReady <= 1'b0;
    insEn    <= 1'b0;
    insAddr  <= '0;
    insBanks <= '0;
    insII    <= '0;
    chkEn    <= 1'b0;
    chkAddr  <= '0;
    chkBanks <= '0;
    chkII    <= '0;
    retEn    <= 1'b0;
    retII    <= '0;
    flush    <= 1'b0;
  endtask

  task automatic waitReady(output bit ok);
    int cycles;
    ok = 1'b0;
    cycles = 0;
    while (!ok && cycles < READY_TIMEOUT) begin
      @(negedge clk);
      if (insReady) begin
        ok = 1'b1;
      end
      cycles++;
    end
  endtask

  // present one operation for a cycle, then idle the inputs
  task automatic runOp(input logic [3:0] op, input lineAddrT addr, input bankMaskT banks,
                       input iiTagT tag, input logic ev, input logic ec, input logic er);
    bit ready;
    ready = 1'b1;
    if (op == OP_INSERT && er) begin
      waitReady(ready);
      if (!ready) begin
        $display("timeout at %0t: insReady stayed low before insert of tag %h", $time, tag);
        timeouts++;
      end
    end
    @(posedge clk);
    opValid  <= 1'b1;
    expValid <= ev;
    expConfl <= ec;
    expReady <= er;
    case (op)
      OP_INSERT: begin
        insEn    <= 1'b1;
        insAddr  <= addr;
        insBanks <= banks;
        insII    <= tag;
      end
      OP_CHECK: begin
        chkEn    <= 1'b1;
        chkAddr  <= addr;
        chkBanks <= banks;
        chkII    <= tag;
      end
      OP_RETIRE: begin
        retEn <= 1'b1;
        retII <= tag;
      end
      OP_FLUSH: begin
        flush <= 1'b1;
      end
      default: begin
      end
    endcase
    @(posedge clk);
    clearInputs();
  endtask

  initial begin
    int fd;
    int fields;
    logic [8*160-1:0] lineBuf;
    logic [3:0] op;
    lineAddrT addr;
    bankMaskT banks;
    iiTagT    tag;
    logic ev;
    logic ec;
    logic er;

    timeouts   = 0;
    fileErrors = 0;
    rst      = 1'b1;
    opValid  = 1'b0;
    expValid = 1'b0;
    expConfl = 1'b0;
    expReady = 1'b0;
    insEn    = 1'b0;
    insAddr  = '0;
    insBanks = '0;
    insII    = '0;
    chkEn    = 1'b0;
    chkAddr  = '0;
    chkBanks = '0;
    chkII    = '0;
    retEn    = 1'b0;
    retII    = '0;
    flush    = 1'b0;

    repeat (5) @(posedge clk);
    rst <= 1'b0;

    fd = $fopen("tb/ldqStim.txt", "r");
    if (fd == 0) begin
      $display("could not open stimulus file tb/ldqStim.txt");
      fileErrors++;
    end else begin
      while (!$feof(fd)) begin
        lineBuf = '0;
        if ($fgets(lineBuf, fd) != 0) begin
          // comment and blank lines do not parse
          fields = $sscanf(lineBuf, "%h %h %h %h %h %h %h", op, addr, banks, tag, ev, ec, er);
          if (fields == 7) begin
            runOp(op, addr, banks, tag, ev, ec, er);
          end
        end
      end
      $fclose(fd);
    end

    // let the last retire result reach the checker
    repeat (3) @(posedge clk);
    $display("errors: %0d mismatches, %0d timeouts, %0d file errors",
             mismatches, timeouts, fileErrors);
    if (mismatches == 0 && timeouts == 0 && fileErrors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: tb/ldqStim.txt
# op addr banks tag expValid expConfl expReady, all hex
# op: 0 idle, 1 insert, 2 store check, 3 retire, 4 flush
# conflict marking
1 0000000a0 0000000f 010 0 0 1
2 0000000a0 00000001 020 0 0 1
3 000000000 00000000 010 1 1 1
# no overlap: disjoint banks, then another address
1 0000000a0 0000000f 030 0 0 1
1 0000000b0 000000f0 040 0 0 1
2 0000000a0 000000f0 050 0 0 1
2 0000000c0 ffffffff 050 0 0 1
3 000000000 00000000 030 1 0 1
3 000000000 00000000 040 1 0 1
# same group, store at a higher position leaves the load clean
1 000000100 00000100 065 0 0 1
2 000000100 00000100 067 0 0 1
3 000000000 00000000 065 1 0 1
# same group, store at a lower and at an equal position
1 000000100 00000100 065 0 0 1
2 000000100 00000100 063 0 0 1
3 000000000 00000000 065 1 1 1
1 000000100 00000100 075 0 0 1
2 000000100 00000100 075 0 0 1
3 000000000 00000000 075 1 1 1
# already retired and absent tags
3 000000000 00000000 075 0 0 1
3 000000000 00000000 3ff 0 0 1
# fill to the stall threshold
1 000000200 00000001 101 0 0 1
1 000000200 00000001 102 0 0 1
1 000000200 00000001 103 0 0 1
1 000000200 00000001 104 0 0 1
1 000000200 00000001 105 0 0 1
1 000000200 00000001 106 0 0 1
# back-pressured insert is dropped, one retire reopens
1 000000200 00000001 107 0 0 0
3 000000000 00000000 107 0 0 0
3 000000000 00000000 103 1 0 0
1 000000200 00000001 108 0 0 1
0 000000000 00000000 000 0 0 0
3 000000000 00000000 108 1 0 0
# flush after a store that marks every load
2 000000200 00000001 200 0 0 1
4 000000000 00000000 000 0 0 1
0 000000000 00000000 000 0 0 1
3 000000000 00000000 101 0 0 1
3 000000000 00000000 106 0 0 1
1 000000300 00000001 111 0 0 1
3 000000000 00000000 111 1 0 1

// File: build.f
rtl/ldqPkg.sv
rtl/ldqEntry.sv
rtl/ldqArray.sv
rtl/ldqAlloc.sv
rtl/ldqTop.sv
tb/ldqTop_assertions.sv
tb/ldqChecker.sv
tb/ldqTb.sv

// File: Bender.yml
package:
  name: ldq_tracker

sources:
  - rtl/ldqPkg.sv
  - rtl/ldqEntry.sv
  - rtl/ldqArray.sv
  - rtl/ldqAlloc.sv
  - rtl/ldqTop.sv
  - target: simulation
    files:
      - tb/ldqTop_assertions.sv
      - tb/ldqChecker.sv
      - tb/ldqTb.sv
